// ==== include/pid_controller_consts.svh ====
`ifndef PID_CONTROLLER_CONSTS_SVH
`define PID_CONTROLLER_CONSTS_SVH

// channel count and widths
`define N_CHAN          4       // loop channels, adc n feeds dac n
`define W_CHAN          2       // channel number
`define W_ADC           18      // signed adc sample
`define W_PID           18      // signed pid output
`define W_DAC           16      // dac8568 code

// arithmetic scaling
`define PID_SHIFT       8       // pid sum >>> this, gives fractional gain
`define OPP_SHIFT       2       // pid output >>> this before offsetting

// output side
`define DIQ_DEPTH       8       // dac instruction queue entries
`define DAC_FRAME_BITS  24      // cmd + chan + code
`define DAC_GAP         2       // idle cycles, nsync high between frames

`endif

// ==== pid_controller.f ====
+incdir+include
source/pid_controller_pkg.sv
source/oversample_filter.sv
source/pid_core.sv
source/output_preprocessor.sv
source/dac_instr_queue.sv
source/dac_controller.sv
source/pid_controller.sv
sim/pid_controller_assertions.sv
sim/pid_controller_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the pid_controller testbench with verilator, run it, scan the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module pid_controller_tb -f pid_controller.f \
	-o pid_controller_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "build failed, see build.log"
	exit 1
fi

./obj_dir/pid_controller_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q '>>> FAIL' sim.log; then
	exit 1
fi
exit 0

// ==== sim/pid_controller_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pid_controller_consts.svh"

module pid_controller_assertions (
	input wire                            clk50,
	input wire                            rst_n,
	input wire                            sample_valid,
	input wire                            sample_ready,
	input wire pid_controller_pkg::adc_t  sample_data,
	input wire                            dac_nsync,
	input wire                            dac_sclk
);

	logic [7:0] low_run;  // consecutive cycles with nsync low

	always_ff @(posedge clk50) begin
		if (!rst_n) begin
			low_run <= '0;
		end else if (dac_nsync) begin
			low_run <= '0;
		end else begin
			low_run <= low_run + 8'd1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// serial pins
	nsync_after_reset: assert property (@(posedge clk50) !rst_n |=> dac_nsync)
		else $error("dac_nsync low in the cycle after reset");

	sclk_idle_low: assert property (@(posedge clk50) disable iff (!rst_n)
		dac_nsync |-> !dac_sclk)
		else $error("dac_sclk high while dac_nsync is high");

	// one frame is two clocks per bit
	frame_length: assert property (@(posedge clk50) disable iff (!rst_n)
		$rose(dac_nsync) |-> low_run == 8'(`DAC_FRAME_BITS * 2))
		else $error("dac_nsync low for %0d cycles", low_run);

	frame_not_long: assert property (@(posedge clk50) disable iff (!rst_n)
		!dac_nsync |-> low_run < 8'(`DAC_FRAME_BITS * 2))
		else $error("dac_nsync held low past the frame length");

	sample_hold: assert property (@(posedge clk50) disable iff (!rst_n)
		(sample_valid && !sample_ready) |=> $stable(sample_data))
		else $error("sample_data changed while stalled");

endmodule

bind pid_controller pid_controller_assertions chk (
	.clk50        (clk50),
	.rst_n        (rst_n),
	.sample_valid (sample_valid),
	.sample_ready (sample_ready),
	.sample_data  (sample_data),
	.dac_nsync    (dac_nsync),
	.dac_sclk     (dac_sclk)
);

`default_nettype wire

// ==== sim/pid_controller_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pid_controller_consts.svh"

module pid_controller_tb;

	import pid_controller_pkg::*;

	localparam int N_SAMPLES      = 40 + 64 + 160 + 40 + 48;  // all phases
	localparam int TIMEOUT_CYCLES = N_SAMPLES * 60 + 1000;

	logic      clk50;
	logic      rst_n;
	logic      sample_valid;
	logic      sample_ready;
	chan_t     sample_chan;
	adc_t      sample_data;
	logic [1:0] osf_shift;
	coef_t     setpoint;
	coef_t     p_coef;
	coef_t     i_coef;
	coef_t     d_coef;
	dac_code_t out_min;
	dac_code_t out_max;
	logic      dac_nsync;
	logic      dac_sclk;
	logic      dac_din;

	// reference model state, one slot per channel
	longint    m_sum [`N_CHAN];
	int        m_cnt [`N_CHAN];
	int        m_integ [`N_CHAN];  // 32 bit, wraps like the integrator
	int        m_prev [`N_CHAN];
	chan_t     exp_chan [$];
	dac_code_t exp_code [$];

	logic [`DAC_FRAME_BITS-1:0] frame_bits;
	int        nbits;
	logic      sclk_prev;
	logic      saw_stall;       // sample_ready seen low under valid
	int        frames = 0;
	int        cycles = 0;

	pid_controller DUT (
		.clk50        (clk50),
		.rst_n        (rst_n),
		.sample_valid (sample_valid),
		.sample_ready (sample_ready),
		.sample_chan  (sample_chan),
		.sample_data  (sample_data),
		.osf_shift    (osf_shift),
		.setpoint     (setpoint),
		.p_coef       (p_coef),
		.i_coef       (i_coef),
		.d_coef       (d_coef),
		.out_min      (out_min),
		.out_max      (out_max),
		.dac_nsync    (dac_nsync),
		.dac_sclk     (dac_sclk),
		.dac_din      (dac_din)
	);

	initial begin
		clk50 = 1'b0;
		forever #50 clk50 = ~clk50;  // 100 ns period
	end

	//////////////////////////////////////////////////////////////////////
	// error reporting and compares
	task automatic abort_run(input string why);
		$display("%s", why);
		$display(">>> FAIL");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_cmd(input dac_cmd_t got, input dac_cmd_t exp);
		if (got !== exp) begin
			abort_run($sformatf("Mismatch dac_cmd: got %h expected %h", got, exp));
		end
	endtask

	task automatic check_chan(input chan_t got, input chan_t exp);
		if (got !== exp) begin
			abort_run($sformatf("Mismatch dac_chan: got %h expected %h", got, exp));
		end
	endtask

	task automatic check_code(input dac_code_t got, input dac_code_t exp);
		if (got !== exp) begin
			abort_run($sformatf("Mismatch dac_code: got %h expected %h", got, exp));
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// reference model, filter then pid then offset and clamp
	task automatic model_sample(input int ch, input int data);
		longint avg;
		longint err;
		longint diff;
		longint total;
		longint pid;
		longint val;
		int     integ_new;
		m_sum[ch] = m_sum[ch] + data;
		m_cnt[ch] = m_cnt[ch] + 1;
		if (m_cnt[ch] == (1 << osf_shift)) begin  // group complete
			avg       = m_sum[ch] >>> osf_shift;    // floor division
			m_sum[ch] = 0;
			m_cnt[ch] = 0;
			err       = longint'(setpoint) - avg;
			integ_new = m_integ[ch] + int'(err);
			diff      = err - longint'(m_prev[ch]);
			m_integ[ch] = integ_new;
			m_prev[ch]  = int'(err);
			total = longint'(p_coef) * err + longint'(i_coef) * longint'(integ_new)
				+ longint'(d_coef) * diff;
			pid = total >>> `PID_SHIFT;
			if (pid > 131071) pid = 131071;     // pid_t saturation
			if (pid < -131072) pid = -131072;
			val = (pid >>> `OPP_SHIFT) + 32768;
			if (val < 0) val = 0;
			if (val > 65535) val = 65535;
			if (val < longint'(out_min)) val = longint'(out_min);
			if (val > longint'(out_max)) val = longint'(out_max);
			exp_chan.push_back(chan_t'(ch));
			exp_code.push_back(dac_code_t'(val));
		end
	endtask

	task automatic check_frame(input logic [`DAC_FRAME_BITS-1:0] f);
		if (exp_code.size() == 0) begin
			abort_run("a DAC frame arrived while no result was expected");
		end else if (f[19:18] != 2'b00) begin
			abort_run("upper bits of the frame's channel field are not zero");
		end else begin
			check_cmd(dac_cmd_t'(f[23:20]), DAC_WRITE_UPDATE);
			check_chan(chan_t'(f[17:16]), exp_chan.pop_front());
			check_code(dac_code_t'(f[15:0]), exp_code.pop_front());
			frames++;
		end
	endtask

	// everything sampled mid cycle, where dut outputs are settled
	always @(negedge clk50) begin
		if (rst_n && sample_valid && sample_ready) begin
			model_sample(int'(sample_chan), int'(sample_data));
		end
		if (rst_n && sample_valid && !sample_ready) begin
			saw_stall = 1'b1;
		end
		if (!rst_n || dac_nsync) begin
			nbits = 0;
		end else if (sclk_prev && !dac_sclk) begin  // dac takes din on the fall
			frame_bits = {frame_bits[`DAC_FRAME_BITS-2:0], dac_din};
			nbits++;
			if (nbits == `DAC_FRAME_BITS) begin
				check_frame(frame_bits);
				nbits = 0;
			end
		end
		sclk_prev = dac_sclk;
	end

	always @(posedge clk50) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			abort_run("timeout, the expected DAC frames did not all arrive");
		end
	end

	//////////////////////////////////////////////////////////////////////
	// stimulus
	task automatic apply_reset();
		rst_n        = 1'b0;
		sample_valid = 1'b0;
		repeat (2) @(posedge clk50);
		#1;
		for (int c = 0; c < `N_CHAN; c++) begin
			m_sum[c]   = 0;
			m_cnt[c]   = 0;
			m_integ[c] = 0;
			m_prev[c]  = 0;
		end
		rst_n = 1'b1;
		if (dac_nsync !== 1'b1 || dac_sclk !== 1'b0 || dac_din !== 1'b0
				|| sample_ready !== 1'b1) begin
			abort_run("outputs are not at their idle values after reset");
		end
	endtask

	// valid stays up until the transfer edge
	task automatic send_sample(input chan_t ch, input adc_t d);
		sample_valid = 1'b1;
		sample_chan  = ch;
		sample_data  = d;
		@(negedge clk50);
		while (!sample_ready) @(negedge clk50);
		@(posedge clk50);
		#1;
	endtask

	task automatic run_phase(input int n, input int max_gap, input logic [1:0] shift,
			input coef_t p, input coef_t i, input coef_t d,
			input dac_code_t lo, input dac_code_t hi, input logic need_stall);
		int gap;
		osf_shift = shift;      // config settles during reset
		setpoint  = coef_t'($urandom);
		p_coef    = p;
		i_coef    = i;
		d_coef    = d;
		out_min   = lo;
		out_max   = hi;
		saw_stall = 1'b0;
		apply_reset();
		for (int k = 0; k < n; k++) begin
			send_sample(chan_t'($urandom_range(`N_CHAN - 1, 0)), adc_t'($urandom));
			gap = $urandom_range(max_gap, 0);
			if (gap > 0) begin
				sample_valid = 1'b0;
				repeat (gap) @(posedge clk50);
				#1;
			end
		end
		sample_valid = 1'b0;
		while (exp_code.size() != 0) @(posedge clk50);
		repeat (4) @(posedge clk50);  // let the last gap finish
		#1;
		if (need_stall && !saw_stall) begin
			abort_run("sample_ready never dropped under dense input");
		end
	endtask

	function automatic coef_t small_coef();
		return coef_t'($signed($urandom_range(16, 0)) - 8);
	endfunction

	initial begin
		dac_code_t lo;
		void'($urandom(32'h4ab5));
		rst_n        = 1'b0;
		sample_valid = 1'b0;
		sample_chan  = '0;
		sample_data  = '0;
		osf_shift    = 2'd0;
		setpoint     = '0;
		p_coef       = '0;
		i_coef       = '0;
		d_coef       = '0;
		out_min      = 16'h0000;
		out_max      = 16'hffff;
		sclk_prev    = 1'b0;
		nbits        = 0;
		// proportional only, one frame per sample
		run_phase(40, 3, 2'd0, 16'sd1, 16'sd0, 16'sd0, 16'h0000, 16'hffff, 1'b0);
		// groups of four, channels interleaved
		run_phase(64, 3, 2'd2, 16'sd1, 16'sd0, 16'sd0, 16'h0000, 16'hffff, 1'b0);
		// full range gains, saturation and per channel integrators
		run_phase(160, 3, 2'($urandom_range(3, 0)), coef_t'($urandom), coef_t'($urandom),
			coef_t'($urandom), 16'h0000, 16'hffff, 1'b0);
		// narrow output window around mid scale
		lo = dac_code_t'($urandom_range(32500, 31000));
		run_phase(40, 3, 2'd0, small_coef(), small_coef(), small_coef(),
			lo, lo + dac_code_t'($urandom_range(2000, 200)), 1'b0);
		// back to back samples fill the queue
		run_phase(48, 0, 2'd0, small_coef(), small_coef(), small_coef(),
			16'h0000, 16'hffff, 1'b1);
		repeat (120) @(posedge clk50);  // a stray frame would show up here
		if (nbits != 0 || dac_nsync !== 1'b1 || dac_sclk !== 1'b0) begin
			abort_run("serial output did not return to idle after the last frame");
		end else begin
			$display(">>> PASS");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== source/dac_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pid_controller_consts.svh"

module dac_controller (
	input  wire                              clk50,
	input  wire                              rst_n,
	input  wire                              q_valid,
	output logic                             q_ready,
	input  wire pid_controller_pkg::chan_t      q_chan,
	input  wire pid_controller_pkg::dac_code_t  q_code,
	output logic                             dac_nsync,
	output logic                             dac_sclk,
	output logic                             dac_din
);

	import pid_controller_pkg::*;

	localparam int FRAME_BITS = `DAC_FRAME_BITS;
	localparam int W_BIT      = $clog2(FRAME_BITS);
	localparam int W_GAP      = $clog2(`DAC_GAP + 1);

	dac_state_t            state;
	logic [FRAME_BITS-1:0] shreg;    // msb drives din
	logic [FRAME_BITS-1:0] frame;
	logic [W_BIT-1:0]      bit_cnt;  // bit now on din
	logic [W_GAP-1:0]      gap_cnt;

	// cmd | chan zero extended to 4 | code, msb first
	assign frame   = {DAC_WRITE_UPDATE, 4'(q_chan), q_code};
	assign q_ready = (state == DAC_IDLE);
	assign dac_din = shreg[FRAME_BITS-1];

	//////////////////////////////////////////////////////////////////////
	// each bit: one cycle sclk high, one low, dac samples on the fall
	always_ff @(posedge clk50) begin
		if (!rst_n) begin
			state     <= DAC_IDLE;
			dac_nsync <= 1'b1;
			dac_sclk  <= 1'b0;
			shreg     <= '0;
			bit_cnt   <= '0;
			gap_cnt   <= '0;
		end else begin
			case (state)
				DAC_IDLE: begin
					if (q_valid) begin
						shreg     <= frame;
						dac_nsync <= 1'b0;  // frame start
						dac_sclk  <= 1'b1;
						bit_cnt   <= '0;
						state     <= DAC_SHIFT;
					end
				end
				DAC_SHIFT: begin
					if (dac_sclk) begin
						dac_sclk <= 1'b0;
					end else if (bit_cnt == W_BIT'(FRAME_BITS - 1)) begin
						dac_nsync <= 1'b1;
						shreg     <= shreg << 1;  // empties, din back low
						gap_cnt   <= '0;
						state     <= DAC_GAP;
					end else begin
						dac_sclk <= 1'b1;  // din moves on the rise, steady at the fall
						shreg    <= shreg << 1;
						bit_cnt  <= bit_cnt + 1'b1;
					end
				end
				DAC_GAP: begin
					if (gap_cnt == W_GAP'(`DAC_GAP - 1)) begin
						state <= DAC_IDLE;
					end else begin
						gap_cnt <= gap_cnt + 1'b1;
					end
				end
				default: state <= DAC_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== source/dac_instr_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pid_controller_consts.svh"

module dac_instr_queue #(
	parameter int DEPTH = `DIQ_DEPTH
) (
	input  wire                              clk50,
	input  wire                              rst_n,
	input  wire                              code_valid,
	output logic                             code_ready,
	input  wire pid_controller_pkg::chan_t      code_chan,
	input  wire pid_controller_pkg::dac_code_t  code,
	output logic                             q_valid,
	input  wire                              q_ready,
	output pid_controller_pkg::chan_t        q_chan,
	output pid_controller_pkg::dac_code_t    q_code
);

	import pid_controller_pkg::*;

	localparam int W_PTR = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int W_CNT = $clog2(DEPTH + 1);

	chan_t            mem_chan [DEPTH];
	dac_code_t        mem_code [DEPTH];
	logic [W_PTR-1:0] wr_ptr;
	logic [W_PTR-1:0] rd_ptr;
	logic [W_CNT-1:0] count;   // entries held
	logic             wr_en;
	logic             rd_en;

	assign code_ready = (count != W_CNT'(DEPTH));  // back-pressure only when full
	assign q_valid    = (count != '0);
	assign wr_en      = code_valid && code_ready;
	assign rd_en      = q_valid && q_ready;
	assign q_chan     = mem_chan[rd_ptr];  // head of queue
	assign q_code     = mem_code[rd_ptr];

	//////////////////////////////////////////////////////////////////////
	// pointers wrap at DEPTH, need not be a power of two
	always_ff @(posedge clk50) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= (wr_ptr == W_PTR'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (rd_en) begin
				rd_ptr <= (rd_ptr == W_PTR'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({wr_en, rd_en})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;  // none, or both at once
			endcase
		end
	end

	always_ff @(posedge clk50) begin
		if (wr_en) begin
			mem_chan[wr_ptr] <= code_chan;
			mem_code[wr_ptr] <= code;
		end
	end

endmodule

`default_nettype wire

// ==== source/output_preprocessor.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pid_controller_consts.svh"

module output_preprocessor (
	input  wire                              clk50,
	input  wire                              rst_n,
	input  wire                              pid_valid,
	output logic                             pid_ready,
	input  wire pid_controller_pkg::chan_t      pid_chan,
	input  wire pid_controller_pkg::pid_t       pid_data,
	input  wire pid_controller_pkg::dac_code_t  out_min,
	input  wire pid_controller_pkg::dac_code_t  out_max,
	output logic                             code_valid,
	input  wire                              code_ready,
	output pid_controller_pkg::chan_t        code_chan,
	output pid_controller_pkg::dac_code_t    code
);

	import pid_controller_pkg::*;

	typedef logic signed [19:0] wide_t;  // room for offset math and compares

	localparam wide_t MID  = 20'sd32768;  // bipolar zero -> dac mid-scale

	wide_t shifted;
	wide_t offs;     // spans 0..65535 for any pid_t
	wide_t lo;
	wide_t hi;
	wide_t val;
	logic  pid_fire;

	assign pid_ready = !code_valid || code_ready;
	assign pid_fire  = pid_valid && pid_ready;

	assign shifted = pid_data >>> `OPP_SHIFT;  // sign kept
	assign offs    = shifted + MID;
	assign lo      = $signed({4'b0000, out_min});
	assign hi      = $signed({4'b0000, out_max});

	// user window, max wins if window is inverted
	always_comb begin
		val = offs;
		if (val < lo) begin
			val = lo;
		end
		if (val > hi) begin
			val = hi;
		end
	end

	always_ff @(posedge clk50) begin
		if (!rst_n) begin
			code_valid <= 1'b0;
		end else if (pid_ready) begin
			code_valid <= pid_valid;
		end
	end

	always_ff @(posedge clk50) begin
		if (pid_fire) begin
			code_chan <= pid_chan;
			code      <= val[15:0];
		end
	end

endmodule

`default_nettype wire

// ==== source/oversample_filter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pid_controller_consts.svh"

module oversample_filter (
	input  wire                         clk50,
	input  wire                         rst_n,
	input  wire                         in_valid,
	output logic                        in_ready,
	input  wire pid_controller_pkg::chan_t in_chan,
	input  wire pid_controller_pkg::adc_t  in_data,
	input  wire [1:0]                   osf_shift,   // average 2^osf_shift samples
	output logic                        avg_valid,
	input  wire                         avg_ready,
	output pid_controller_pkg::chan_t   avg_chan,
	output pid_controller_pkg::adc_t    avg_data
);

	import pid_controller_pkg::*;

	typedef logic [3:0] cnt_t;  // reaches 8 at osf_shift 3

	acc_t  sum [`N_CHAN];       // running sum per channel
	cnt_t  cnt [`N_CHAN];       // samples taken in the current group
	logic  in_fire;
	logic  last;                // this sample closes its channel's group
	acc_t  new_sum;

	assign in_ready = !avg_valid || avg_ready;  // output reg empty or draining
	assign in_fire  = in_valid && in_ready;
	assign new_sum  = sum[in_chan] + acc_t'(in_data);  // sign extended add
	assign last     = (cnt[in_chan] + cnt_t'(1)) == (cnt_t'(1) << osf_shift);

	//////////////////////////////////////////////////////////////////////
	// group bookkeeping
	always_ff @(posedge clk50) begin
		if (!rst_n) begin
			avg_valid <= 1'b0;
			for (int c = 0; c < `N_CHAN; c++) begin
				sum[c] <= '0;
				cnt[c] <= '0;
			end
		end else begin
			if (avg_ready) begin
				avg_valid <= 1'b0;  // average taken downstream
			end
			if (in_fire) begin
				if (last) begin
					avg_valid    <= 1'b1;
					sum[in_chan] <= '0;  // start the next group clean
					cnt[in_chan] <= '0;
				end else begin
					sum[in_chan] <= new_sum;
					cnt[in_chan] <= cnt[in_chan] + cnt_t'(1);
				end
			end
		end
	end

	// average = sum / 2^osf_shift, rounds toward -inf
	always_ff @(posedge clk50) begin
		if (in_fire && last) begin
			avg_chan <= in_chan;
			avg_data <= adc_t'(new_sum >>> osf_shift);
		end
	end

endmodule

`default_nettype wire

// ==== source/pid_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module pid_controller (
	input  wire                              clk50,       // 50MHz system clock
	input  wire                              rst_n,
	input  wire                              sample_valid,
	output logic                             sample_ready,
	input  wire pid_controller_pkg::chan_t      sample_chan,
	input  wire pid_controller_pkg::adc_t       sample_data,
	input  wire [1:0]                        osf_shift,
	input  wire pid_controller_pkg::coef_t      setpoint,
	input  wire pid_controller_pkg::coef_t      p_coef,
	input  wire pid_controller_pkg::coef_t      i_coef,
	input  wire pid_controller_pkg::coef_t      d_coef,
	input  wire pid_controller_pkg::dac_code_t  out_min,
	input  wire pid_controller_pkg::dac_code_t  out_max,
	output logic                             dac_nsync,   // -> dac8568
	output logic                             dac_sclk,
	output logic                             dac_din
);

	import pid_controller_pkg::*;

	//////////////////////////////////////////////////////////////////////
	// stage links

	logic      avg_valid;   // osf -> pid
	logic      avg_ready;
	chan_t     avg_chan;
	adc_t      avg_data;
	logic      pid_valid;   // pid -> opp
	logic      pid_ready;
	chan_t     pid_chan;
	pid_t      pid_data;
	logic      code_valid;  // opp -> queue
	logic      code_ready;
	chan_t     code_chan;
	dac_code_t code;
	logic      q_valid;     // queue -> serial out
	logic      q_ready;
	chan_t     q_chan;
	dac_code_t q_code;

	oversample_filter osf (
		.clk50		(clk50),
		.rst_n		(rst_n),
		.in_valid	(sample_valid),
		.in_ready	(sample_ready),
		.in_chan	(sample_chan),
		.in_data	(sample_data),
		.osf_shift	(osf_shift),
		.avg_valid	(avg_valid),
		.avg_ready	(avg_ready),
		.avg_chan	(avg_chan),
		.avg_data	(avg_data)
	);

	pid_core pid (
		.clk50		(clk50),
		.rst_n		(rst_n),
		.avg_valid	(avg_valid),
		.avg_ready	(avg_ready),
		.avg_chan	(avg_chan),
		.avg_data	(avg_data),
		.setpoint	(setpoint),
		.p_coef		(p_coef),
		.i_coef		(i_coef),
		.d_coef		(d_coef),
		.pid_valid	(pid_valid),
		.pid_ready	(pid_ready),
		.pid_chan	(pid_chan),
		.pid_data	(pid_data)
	);

	// pid channel n always lands on dac channel n
	output_preprocessor opp (
		.clk50		(clk50),
		.rst_n		(rst_n),
		.pid_valid	(pid_valid),
		.pid_ready	(pid_ready),
		.pid_chan	(pid_chan),
		.pid_data	(pid_data),
		.out_min	(out_min),
		.out_max	(out_max),
		.code_valid	(code_valid),
		.code_ready	(code_ready),
		.code_chan	(code_chan),
		.code		(code)
	);

	dac_instr_queue dac_iq (
		.clk50		(clk50),
		.rst_n		(rst_n),
		.code_valid	(code_valid),
		.code_ready	(code_ready),
		.code_chan	(code_chan),
		.code		(code),
		.q_valid	(q_valid),
		.q_ready	(q_ready),
		.q_chan		(q_chan),
		.q_code		(q_code)
	);

	dac_controller dac_cntrl (
		.clk50		(clk50),
		.rst_n		(rst_n),
		.q_valid	(q_valid),
		.q_ready	(q_ready),
		.q_chan		(q_chan),
		.q_code		(q_code),
		.dac_nsync	(dac_nsync),
		.dac_sclk	(dac_sclk),
		.dac_din	(dac_din)
	);

endmodule

`default_nettype wire

// ==== source/pid_controller_pkg.sv ====
`default_nettype none

`include "pid_controller_consts.svh"

package pid_controller_pkg;

	typedef logic [`W_CHAN-1:0]        chan_t;      // loop channel number
	typedef logic signed [`W_ADC-1:0]  adc_t;       // raw or averaged sample
	typedef logic signed [`W_PID-1:0]  pid_t;       // saturated correction
	typedef logic signed [15:0]        coef_t;      // integer gains and setpoint
	typedef logic signed [31:0]        acc_t;       // integrator, sample sums
	typedef logic [`W_DAC-1:0]         dac_code_t;  // offset binary code

	// dac8568 command nibble
	typedef enum logic [3:0] {
		DAC_WRITE_INPUT  = 4'b0000,  // write input reg only
		DAC_WRITE_UPDATE = 4'b0011   // write and update the channel
	} dac_cmd_t;

	// serial controller states
	typedef enum logic [1:0] {
		DAC_IDLE,
		DAC_SHIFT,
		DAC_GAP
	} dac_state_t;

endpackage

`default_nettype wire

// ==== source/pid_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pid_controller_consts.svh"

module pid_core (
	input  wire                           clk50,
	input  wire                           rst_n,
	input  wire                           avg_valid,
	output logic                          avg_ready,
	input  wire pid_controller_pkg::chan_t   avg_chan,
	input  wire pid_controller_pkg::adc_t    avg_data,
	input  wire pid_controller_pkg::coef_t   setpoint,
	input  wire pid_controller_pkg::coef_t   p_coef,
	input  wire pid_controller_pkg::coef_t   i_coef,
	input  wire pid_controller_pkg::coef_t   d_coef,
	output logic                          pid_valid,
	input  wire                           pid_ready,
	output pid_controller_pkg::chan_t     pid_chan,
	output pid_controller_pkg::pid_t      pid_data
);

	import pid_controller_pkg::*;

	typedef logic signed [47:0] prod_t;  // products and their sum

	localparam prod_t PID_MAX = (prod_t'(1) <<< (`W_PID - 1)) - prod_t'(1);
	localparam prod_t PID_MIN = -PID_MAX - prod_t'(1);

	acc_t  integ [`N_CHAN];     // integrator, wraps on overflow
	acc_t  prev_err [`N_CHAN];  // last error seen, for the d term
	logic  advance;             // whole pipe moves this cycle
	logic  avg_fire;
	acc_t  err;
	acc_t  integ_new;
	acc_t  err_diff;
	logic  s1_valid;
	chan_t s1_chan;
	prod_t p_prod;
	prod_t i_prod;
	prod_t d_prod;
	prod_t sum;
	prod_t sum_sh;
	pid_t  sat;

	assign advance   = !pid_valid || pid_ready;
	assign avg_ready = advance;
	assign avg_fire  = avg_valid && advance;

	assign err       = acc_t'(setpoint) - acc_t'(avg_data);
	assign integ_new = integ[avg_chan] + err;
	assign err_diff  = err - prev_err[avg_chan];

	//////////////////////////////////////////////////////////////////////
	// stage 2 sum, scale and saturate
	assign sum    = p_prod + i_prod + d_prod;
	assign sum_sh = sum >>> `PID_SHIFT;

	always_comb begin
		if (sum_sh > PID_MAX) begin
			sat = pid_t'(PID_MAX);
		end else if (sum_sh < PID_MIN) begin
			sat = pid_t'(PID_MIN);
		end else begin
			sat = pid_t'(sum_sh);
		end
	end

	always_ff @(posedge clk50) begin
		if (!rst_n) begin
			s1_valid  <= 1'b0;
			pid_valid <= 1'b0;
			for (int c = 0; c < `N_CHAN; c++) begin
				integ[c]    <= '0;
				prev_err[c] <= '0;
			end
		end else begin
			if (advance) begin
				s1_valid  <= avg_fire;
				pid_valid <= s1_valid;
			end
			if (avg_fire) begin
				integ[avg_chan]    <= integ_new;
				prev_err[avg_chan] <= err;
			end
		end
	end

	always_ff @(posedge clk50) begin
		if (avg_fire) begin  // stage 1 products
			s1_chan <= avg_chan;
			p_prod  <= prod_t'(p_coef) * prod_t'(err);
			i_prod  <= prod_t'(i_coef) * prod_t'(integ_new);
			d_prod  <= prod_t'(d_coef) * prod_t'(err_diff);
		end
		if (advance && s1_valid) begin
			pid_chan <= s1_chan;
			pid_data <= sat;
		end
	end

endmodule

`default_nettype wire
